// ==== list.f ====
verilog/gfx_pkg.sv
verilog/gfx_trans_if.sv
verilog/gfx_skid_buf.sv
verilog/gfx_req_pipe.sv
verilog/gfx_mem_ctrl.sv
verilog/gfx_mem.sv
testbench/gfx_mem_sva.sv
testbench/gfx_mem_tb.sv

// ==== testbench/gfx_mem_testdata.txt ====
// client coord data gap, one request per line
// client 0 is a raster write, 1 a scan-out read, 2 both clients at once
0 00010 1111 02
0 00011 2222 00
1 00010 0000 00
1 00011 0000 00
1 7ffff 0000 01
2 00020 3333 03
1 00020 0000 00
0 40000 4444 00
1 40000 0000 00
1 12345 0000 04
0 00100 a001 00
0 00101 a002 00
0 00102 a003 00
0 00103 a004 00
1 00100 0000 00
1 00101 0000 00
1 00102 0000 00
1 00103 0000 00
2 00100 b005 00
2 00101 b006 01
1 00100 0000 00
1 00101 0000 00
0 5a5a5 c007 00
1 5a5a5 0000 00
0 5a5a5 c008 00
1 5a5a5 0000 00
2 00200 d009 02
1 00200 0000 00
1 3fffe 0000 00
0 00300 e00a 00
1 00300 0000 00
1 00007 0000 05

// ==== testbench/gfx_mem_tb.sv ====
`timescale 1ns/1ps

module gfx_mem_tb;

	import gfx_pkg::*;

	localparam int TRANS_DEPTH = DEF_TRANS_DEPTH;
	localparam int RDATA_DEPTH = DEF_RDATA_DEPTH;
	localparam int N_REQ = 32;
	localparam int N_QUIET = 10; // leading entries run with the memory never stalling

	typedef struct packed {
		mem_addr address;
		logic    write;
		mem_word writedata;
		logic    quiet;      // accepted while mem_waitrequest was held low
		int      accept_cyc;
	} exp_trans;

	typedef struct packed {
		mem_word data;
		int      due;
	} rd_return;

	logic      clk, arst_n;
	logic      mem_waitrequest, mem_readdatavalid, mem_read, mem_write;
	mem_word   mem_readdata, mem_writedata;
	mem_addr   mem_address;
	logic      rop_write, rop_waitrequest;
	mem_word   rop_writedata;
	half_coord rop_address;
	logic      fb_read, fb_waitrequest, fb_readdatavalid;
	half_coord fb_address;
	mem_word   fb_readdata;

	logic [31:0] testdata[4*N_REQ];
	exp_trans    exp_q[$];
	mem_word     exp_rd[$];
	rd_return    ret_q[$];
	int          fb_due[$];           // cycle at which each returned word reaches scan-out
	mem_word     shadow[mem_addr];    // the contents the memory should hold after each request
	mem_word     mem_model[mem_addr]; // what the memory really holds
	int          cycle = 0;
	int          errors = 0;
	int          n_trans = 0;
	int          n_reads = 0;
	int          burst = 0;
	int          last_due = 0;
	integer      seed = 30368;
	logic        quiet = 1'b1;

	gfx_mem #(.TRANS_DEPTH(TRANS_DEPTH), .RDATA_DEPTH(RDATA_DEPTH)) i_gfx_mem (.*);

	always #20 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// untouched words read back as a pattern built from every address bit
	function automatic mem_word fill_word(mem_addr a);
		return a[15:0] ^ {7'h2b, a[24:16]};
	endfunction

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		errors++;
		$display("FAILED %s: got %h expected %h", name, got, want);
	endtask

	task automatic accept(logic write, half_coord coord, mem_word data);
		exp_trans e;
		mem_addr  a;
		a = {6'b0, coord};
		e.address = a;
		e.write = write;
		e.writedata = data;
		e.quiet = quiet;
		e.accept_cyc = cycle + 1; // the edge that is coming
		exp_q.push_back(e);
		if (write)
			shadow[a] = data;
		else
			exp_rd.push_back(shadow.exists(a) ? shadow[a] : fill_word(a));
	endtask

	task automatic send(int idx);
		logic [1:0] client;
		half_coord  coord;
		mem_word    data;
		int         gap;
		logic       fb_take, rop_take;
		client = testdata[4*idx][1:0];
		coord = testdata[4*idx+1][18:0];
		data = testdata[4*idx+2][15:0];
		gap = testdata[4*idx+3];
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
		if (client != 2'd1) begin
			rop_write = 1'b1;
			rop_address = coord;
			rop_writedata = data;
		end
		if (client != 2'd0) begin
			fb_read = 1'b1;
			fb_address = coord;
		end
		while (rop_write || fb_read) begin
			@(negedge clk);
			if (fb_read && rop_write && !rop_waitrequest) begin
				errors++;
				$display("raster write was let through while a scan-out read waited");
			end
			fb_take = fb_read && !fb_waitrequest;
			rop_take = rop_write && !fb_read && !rop_waitrequest;
			if (fb_take)
				accept(1'b0, coord, data);
			if (rop_take)
				accept(1'b1, coord, data);
			@(posedge clk);
			#2;
			if (fb_take)
				fb_read = 1'b0;
			if (rop_take)
				rop_write = 1'b0;
		end
	endtask

	task automatic check_issue();
		exp_trans e;
		rd_return r;
		n_trans++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("memory command issued with no request outstanding");
			return;
		end
		e = exp_q.pop_front();
		if (mem_address !== e.address) report_mismatch("mem_address", mem_address, e.address);
		if (mem_read !== !e.write) report_mismatch("mem_read", mem_read, !e.write);
		if (mem_write !== e.write) report_mismatch("mem_write", mem_write, e.write);
		if (e.write && mem_writedata !== e.writedata)
			report_mismatch("mem_writedata", mem_writedata, e.writedata);
		if (e.quiet && cycle + 1 - e.accept_cyc != TRANS_DEPTH + 2)
			report_mismatch("issue latency", cycle + 1 - e.accept_cyc, TRANS_DEPTH + 2);
		if (mem_write) begin
			mem_model[mem_address] = mem_writedata;
		end else begin
			r.data = mem_model.exists(mem_address) ? mem_model[mem_address]
				: fill_word(mem_address);
			r.due = cycle + 1 + $unsigned($random(seed)) % 4;
			if (r.due <= last_due)
				r.due = last_due + 1; // reads come back in order
			last_due = r.due;
			ret_q.push_back(r);
		end
	endtask

	// the memory model samples at the falling edge and drives after the rising one
	always begin : memory
		rd_return r;
		logic     may_stall;
		@(negedge clk);
		may_stall = !quiet;
		if (arst_n && (mem_read || mem_write) && !mem_waitrequest)
			check_issue();
		@(posedge clk);
		#2;
		if (ret_q.size() != 0 && ret_q[0].due <= cycle) begin
			r = ret_q.pop_front();
			mem_readdatavalid = 1'b1;
			mem_readdata = r.data;
			fb_due.push_back(cycle + RDATA_DEPTH);
		end else begin
			mem_readdatavalid = 1'b0;
			mem_readdata = '0;
		end
		if (!may_stall) begin
			mem_waitrequest = 1'b0;
		end else if (burst > 0) begin
			mem_waitrequest = 1'b1;
			burst--;
		end else if ($unsigned($random(seed)) % 4 == 0) begin
			mem_waitrequest = 1'b1;
			burst = $unsigned($random(seed)) % 8; // bursts of up to 8 stalled cycles
		end else begin
			mem_waitrequest = 1'b0;
		end
	end

	always @(negedge clk) begin : check_readdata
		mem_word want;
		int      due;
		if (arst_n && fb_readdatavalid) begin
			n_reads++;
			if (exp_rd.size() == 0) begin
				errors++;
				$display("scan-out read data returned with no read outstanding");
			end else begin
				want = exp_rd.pop_front();
				if (fb_readdata !== want) report_mismatch("fb_readdata", fb_readdata, want);
			end
			if (fb_due.size() == 0) begin
				errors++;
				$display("scan-out read data arrived before the memory returned any");
			end else begin
				due = fb_due.pop_front();
				if (cycle != due)
					report_mismatch("fb_readdatavalid cycle", cycle, due);
			end
		end
	end

	initial begin
		repeat (N_REQ * 40 + 200) @(posedge clk);
		$display("watchdog expired with %0d commands and %0d reads outstanding",
			exp_q.size(), exp_rd.size());
		$display("errors=%0d commands=%0d reads=%0d", errors, n_trans, n_reads);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		mem_waitrequest = 1'b0;
		mem_readdatavalid = 1'b0;
		mem_readdata = '0;
		rop_write = 1'b0;
		rop_writedata = '0;
		rop_address = '0;
		fb_read = 1'b0;
		fb_address = '0;
		$readmemh("testbench/gfx_mem_testdata.txt", testdata);
		if ($isunknown(testdata[4*N_REQ-1])) begin
			errors++;
			$display("test data file is missing or has too few entries");
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		if (mem_read !== 1'b0) report_mismatch("mem_read", mem_read, 1'b0);
		if (mem_write !== 1'b0) report_mismatch("mem_write", mem_write, 1'b0);
		if (fb_readdatavalid !== 1'b0) report_mismatch("fb_readdatavalid", fb_readdatavalid, 1'b0);
		if (rop_waitrequest !== 1'b1) report_mismatch("rop_waitrequest", rop_waitrequest, 1'b1);
		if (fb_waitrequest !== 1'b1) report_mismatch("fb_waitrequest", fb_waitrequest, 1'b1);
		@(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (2) begin
			@(posedge clk);
			#2;
		end

		for (int i = 0; i < N_REQ; i++) begin
			if (i == N_QUIET) begin
				// drain the latency entries before the memory starts stalling
				while (exp_q.size() != 0) begin
					@(posedge clk);
					#2;
				end
				quiet = 1'b0;
			end
			send(i);
		end

		while (exp_q.size() != 0 || exp_rd.size() != 0)
			@(posedge clk);
		repeat (RDATA_DEPTH + 8) @(posedge clk); // room for stray commands or data

		$display("errors=%0d commands=%0d reads=%0d", errors, n_trans, n_reads);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== testbench/gfx_mem_sva.sv ====
`timescale 1ns/1ps

module gfx_mem_sva
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic             mem_read,
	input  logic             mem_write,
	input  logic             mem_waitrequest,
	input  gfx_pkg::mem_addr mem_address,
	input  gfx_pkg::mem_word mem_writedata,
	input  logic             rop_waitrequest,
	input  logic             fb_waitrequest
);

	// one operation at a time on the memory pins
	a_single_op: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	// a stalled command must sit still until the memory takes it
	a_hold_cmd: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_read || mem_write) && mem_waitrequest |=>
			$stable(mem_address) && $stable(mem_writedata) &&
			$stable(mem_read) && $stable(mem_write))
		else $error("memory command changed while waitrequest was high");

	a_one_client: assert property (@(posedge clk) disable iff (!arst_n)
		rop_waitrequest || fb_waitrequest)
		else $error("both client waitrequests are low together");

endmodule

bind gfx_mem gfx_mem_sva i_sva (.*);

// ==== verilog/gfx_mem.sv ====
`timescale 1ns/1ps

module gfx_mem
#(
	parameter int TRANS_DEPTH = gfx_pkg::DEF_TRANS_DEPTH,
	parameter int RDATA_DEPTH = gfx_pkg::DEF_RDATA_DEPTH
)
(
	input  logic              clk,
	input  logic              arst_n,

	input  logic              mem_waitrequest,
	input  logic              mem_readdatavalid,
	input  gfx_pkg::mem_word   mem_readdata,
	output gfx_pkg::mem_addr   mem_address,
	output logic              mem_read,
	output logic              mem_write,
	output gfx_pkg::mem_word   mem_writedata,

	input  logic              rop_write,
	input  gfx_pkg::mem_word   rop_writedata,
	input  gfx_pkg::half_coord rop_address,
	output logic              rop_waitrequest,

	input  logic              fb_read,
	input  gfx_pkg::half_coord fb_address,
	output logic              fb_waitrequest,
	output logic              fb_readdatavalid,
	output gfx_pkg::mem_word   fb_readdata
);

	// the request path loops out of the controller and back into it
	gfx_trans_if ctrl_to_in();
	gfx_trans_if in_to_pipe();
	gfx_trans_if pipe_to_out();
	gfx_trans_if out_to_ctrl();

	gfx_mem_ctrl #(.RDATA_DEPTH(RDATA_DEPTH)) ctrl
	(
		.req(ctrl_to_in),
		.issue(out_to_ctrl),
		.*
	);

	// registered ready here keeps the client handshake off the long path
	gfx_skid_buf in_skid
	(
		.clk(clk),
		.arst_n(arst_n),
		.up(ctrl_to_in),
		.down(in_to_pipe)
	);

	// extra stages so the route to the memory pins can be closed
	gfx_req_pipe #(.TRANS_DEPTH(TRANS_DEPTH)) req_pipe
	(
		.clk(clk),
		.arst_n(arst_n),
		.up(in_to_pipe),
		.down(pipe_to_out)
	);

	gfx_skid_buf out_skid
	(
		.clk(clk),
		.arst_n(arst_n),
		.up(pipe_to_out),
		.down(out_to_ctrl)
	);

endmodule

// ==== verilog/gfx_mem_ctrl.sv ====
`timescale 1ns/1ps

module gfx_mem_ctrl
#(
	parameter int RDATA_DEPTH = gfx_pkg::DEF_RDATA_DEPTH
)
(
	input  logic              clk,
	input  logic              arst_n,

	input  logic              rop_write,
	input  gfx_pkg::mem_word   rop_writedata,
	input  gfx_pkg::half_coord rop_address,
	output logic              rop_waitrequest,

	input  logic              fb_read,
	input  gfx_pkg::half_coord fb_address,
	output logic              fb_waitrequest,
	output logic              fb_readdatavalid,
	output gfx_pkg::mem_word   fb_readdata,

	input  logic              mem_waitrequest,
	input  logic              mem_readdatavalid,
	input  gfx_pkg::mem_word   mem_readdata,
	output gfx_pkg::mem_addr   mem_address,
	output logic              mem_read,
	output logic              mem_write,
	output gfx_pkg::mem_word   mem_writedata,

	gfx_trans_if.src          req,
	gfx_trans_if.snk          issue
);

	import gfx_pkg::*;

	localparam int ADDR_PAD = $bits(mem_addr) - $bits(half_coord);

	mem_trans                 trans_in;
	logic [RDATA_DEPTH-1:0]   rd_valid;
	mem_word                  rd_data[RDATA_DEPTH];

	assign req.valid = rop_write || fb_read;
	assign req.trans = trans_in;

	/* scan-out wins every tie. A missed read shows up on screen as a glitch,
	 * while a raster write can just wait its turn. The client that loses
	 * sees waitrequest stuck high, so it keeps its request on the bus
	 */
	always_comb begin
		fb_waitrequest = 1'b1;
		rop_waitrequest = 1'b1;

		trans_in.writedata = rop_writedata; // ignored when the beat is a read

		if (fb_read) begin
			fb_waitrequest = !req.ready;
			trans_in.write = 1'b0;
			trans_in.address = {{ADDR_PAD{1'b0}}, fb_address};
		end else begin
			rop_waitrequest = !req.ready;
			trans_in.write = 1'b1;
			trans_in.address = {{ADDR_PAD{1'b0}}, rop_address};
		end
	end

	// the memory takes the beat on the edge where waitrequest is low
	assign issue.ready = !mem_waitrequest;

	assign mem_read = issue.valid && !issue.trans.write;
	assign mem_write = issue.valid && issue.trans.write;
	assign mem_address = issue.trans.address;
	assign mem_writedata = issue.trans.writedata;

	// read data has no back-pressure, it only needs a fixed delay
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_valid <= '0;
		else begin
			rd_valid[0] <= mem_readdatavalid;
			for (int i = 1; i < RDATA_DEPTH; i++)
				rd_valid[i] <= rd_valid[i - 1];
		end
	end

	always_ff @(posedge clk) begin
		rd_data[0] <= mem_readdata;
		for (int i = 1; i < RDATA_DEPTH; i++)
			rd_data[i] <= rd_data[i - 1];
	end

	assign fb_readdatavalid = rd_valid[RDATA_DEPTH-1];
	assign fb_readdata = rd_data[RDATA_DEPTH-1];

endmodule

// ==== verilog/gfx_req_pipe.sv ====
`timescale 1ns/1ps

module gfx_req_pipe
#(
	parameter int TRANS_DEPTH = gfx_pkg::DEF_TRANS_DEPTH
)
(
	input  logic  clk,
	input  logic  arst_n,

	gfx_trans_if.snk up,
	gfx_trans_if.src down
);

	import gfx_pkg::*;

	logic [TRANS_DEPTH-1:0] valid; // one flag per stage
	logic [TRANS_DEPTH-1:0] adv;   // stage may load this cycle
	mem_trans               stage[TRANS_DEPTH];

	assign up.ready = adv[0];

	assign down.valid = valid[TRANS_DEPTH-1];
	assign down.trans = stage[TRANS_DEPTH-1];

	/* a stage can take new contents when it is empty or when the stage
	 * after it is able to take its contents. Empty stages keep loading
	 * while the tail is stalled, which squeezes the bubbles out
	 */
	always_comb begin
		adv[TRANS_DEPTH-1] = !valid[TRANS_DEPTH-1] || down.ready;
		for (int i = TRANS_DEPTH - 2; i >= 0; i--)
			adv[i] = !valid[i] || adv[i + 1];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid <= '0;
		else begin
			if (adv[0])
				valid[0] <= up.valid;

			for (int i = 1; i < TRANS_DEPTH; i++)
				if (adv[i])
					valid[i] <= valid[i - 1];
		end
	end

	always_ff @(posedge clk) begin
		if (adv[0])
			stage[0] <= up.trans;

		for (int i = 1; i < TRANS_DEPTH; i++)
			if (adv[i])
				stage[i] <= stage[i - 1]; // payload follows its valid flag
	end

endmodule

// ==== verilog/gfx_skid_buf.sv ====
`timescale 1ns/1ps

module gfx_skid_buf
(
	input  logic  clk,
	input  logic  arst_n,

	gfx_trans_if.snk up,
	gfx_trans_if.src down
);

	import gfx_pkg::*;

	logic     main_valid, skid_valid, ready_q;
	logic     accept, main_free;
	mem_trans main, skid;

	/* the upstream ready comes straight out of a flop, so the ready path is
	 * cut here. The price is one spare entry that catches the beat which
	 * was already on its way when the downstream side stalled
	 */
	assign up.ready = ready_q;
	assign accept = up.valid && ready_q;
	assign main_free = !main_valid || down.ready; // main empties or hands off this cycle

	assign down.valid = main_valid;
	assign down.trans = main;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
			ready_q <= 1'b0; // comes up one cycle after reset release
		end else if (main_free) begin
			main_valid <= skid_valid || accept;
			skid_valid <= 1'b0;
			ready_q <= 1'b1;
		end else if (accept) begin
			// downstream is stuck, park the beat and close the door
			skid_valid <= 1'b1;
			ready_q <= 1'b0;
		end
	end

	// the parked beat is older than anything upstream, so it goes first
	always_ff @(posedge clk) begin
		if (main_free)
			main <= skid_valid ? skid : up.trans;

		if (accept && !main_free)
			skid <= up.trans;
	end

endmodule

// ==== verilog/gfx_trans_if.sv ====
`timescale 1ns/1ps

interface gfx_trans_if;

	import gfx_pkg::*;

	// a beat moves on a rising clk where valid and ready are both high
	logic     valid;
	logic     ready;
	mem_trans trans; // must hold still while valid waits for ready

	modport src
	(
		output valid,
		output trans,
		input  ready
	);

	modport snk
	(
		input  valid,
		input  trans,
		output ready
	);

endinterface

// ==== verilog/gfx_pkg.sv ====
package gfx_pkg;

	// one pixel as it sits in video memory
	typedef logic [15:0] mem_word;

	// linear framebuffer coordinate, the same for both clients
	typedef logic [18:0] half_coord;

	// memory word address, a half_coord with zero bits on top
	typedef logic [24:0] mem_addr;

	// a single request on its way to the memory pins, 42 bits wide
	typedef struct packed {
		mem_addr address;
		logic    write;     // 1 for a raster write, 0 for a scan-out read
		mem_word writedata; // don't care on reads
	} mem_trans;

	// depth of the request pipeline between the two skid buffers
	parameter int DEF_TRANS_DEPTH = 3;

	// cycles that read data spends on its way back to scan-out
	parameter int DEF_RDATA_DEPTH = 2;

endpackage
